// File: rtl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // One-hot operation select, bit positions below
    localparam int ALU_W = 12;
    typedef logic [ALU_W-1:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SRA  = 9;
    localparam int ALU_PASS = 10; // LUI
    localparam int ALU_LINK = 11; // pc+4 for JAL/JALR

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'h33;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;
    localparam logic [6:0] OP_JAL    = 7'h6f;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_BRANCH = 7'h63;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'h0;
    localparam logic [2:0] F3_BNE  = 3'h1;
    localparam logic [2:0] F3_BLT  = 3'h4;
    localparam logic [2:0] F3_BGE  = 3'h5;
    localparam logic [2:0] F3_BLTU = 3'h6;
    localparam logic [2:0] F3_BGEU = 3'h7;

endpackage

// File: rtl/lane_ifs.sv
`timescale 1ns/1ps

// Dispatcher to lane
interface issue_if;
    logic          valid;
    logic          ready;
    rv_pkg::word_t pc;
    rv_pkg::word_t inst;
    rv_pkg::word_t src1;
    rv_pkg::word_t src2;

    modport dispatch (output valid, pc, inst, src1, src2, input ready);
    modport lane     (input valid, pc, inst, src1, src2, output ready);
endinterface

// Lane to collector
interface result_if;
    logic             valid;
    logic             ready;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    wdata;
    rv_pkg::word_t    target;
    logic             wen;
    logic             redirect;
    logic             illegal;

    modport lane    (output valid, rd, wdata, target, wen, redirect, illegal, input ready);
    modport collect (input valid, rd, wdata, target, wen, redirect, illegal, output ready);
endinterface

// File: rtl/issue_dispatch.sv
`timescale 1ns/1ps

module issue_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    output logic          in_ready,
    input  rv_pkg::word_t in_pc,
    input  rv_pkg::word_t in_inst,
    input  rv_pkg::word_t in_src1,
    input  rv_pkg::word_t in_src2,
    issue_if.dispatch     lanes [NUM_LANES]
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] ptr;
    logic             lane_ready [NUM_LANES];

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_route
        assign lanes[g].valid = in_valid && (ptr == PTR_W'(g));
        assign lanes[g].pc    = in_pc;
        assign lanes[g].inst  = in_inst;
        assign lanes[g].src1  = in_src1;
        assign lanes[g].src2  = in_src2;
        assign lane_ready[g]  = lanes[g].ready;
    end

    assign in_ready = lane_ready[ptr];

    // Round-robin issue order
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (in_valid && in_ready) begin
            if (ptr == PTR_W'(NUM_LANES - 1))
                ptr <= '0;
            else
                ptr <= ptr + 1'b1;
        end
    end

    a_ptr_range: assert property (@(posedge clk) disable iff (rst)
        ptr < NUM_LANES);

endmodule

// File: rtl/decode_exec_lane.sv
`timescale 1ns/1ps

module decode_exec_lane (
    input  logic    clk,
    input  logic    rst,
    issue_if.lane   iss,
    result_if.lane  res
);

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_DONE} lane_state_t;

    lane_state_t state;

    logic [127:0] opc_d;
    logic [127:0] f7_d;
    logic [7:0]   f3_d;

    logic is_reg, is_imm, is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic r_base, r_alt, i_sh0, i_alt, ri_any;
    logic br_eq, br_lt, br_ltu, br_taken;
    logic is_shift;

    rv_pkg::alu_op_t op_d;
    rv_pkg::word_t   imm_i, imm_b, imm_u, imm_j, imm;
    rv_pkg::word_t   a_d, b_d, target_d;

    rv_pkg::alu_op_t  op_q;
    rv_pkg::word_t    a_q, b_q, target_q;
    rv_pkg::reg_idx_t rd_q;
    logic [4:0]       cnt_q;
    logic             wen_q, redirect_q, illegal_q;
    rv_pkg::word_t    alu_res;

    // One-hot field decode
    assign opc_d = 128'd1 << iss.inst[6:0];
    assign f7_d  = 128'd1 << iss.inst[31:25];
    assign f3_d  = 8'd1 << iss.inst[14:12];

    assign is_reg    = opc_d[rv_pkg::OP_REG];
    assign is_imm    = opc_d[rv_pkg::OP_IMM];
    assign is_lui    = opc_d[rv_pkg::OP_LUI];
    assign is_auipc  = opc_d[rv_pkg::OP_AUIPC];
    assign is_jal    = opc_d[rv_pkg::OP_JAL];
    assign is_jalr   = opc_d[rv_pkg::OP_JALR] & f3_d[0];
    assign is_branch = opc_d[rv_pkg::OP_BRANCH] & ~(f3_d[2] | f3_d[3]);

    assign r_base = is_reg & f7_d[7'h00];
    assign r_alt  = is_reg & f7_d[7'h20];
    assign i_sh0  = is_imm & f7_d[7'h00];
    assign i_alt  = is_imm & f7_d[7'h20];
    assign ri_any = r_base | is_imm;

    assign op_d[rv_pkg::ALU_ADD]  = (ri_any & f3_d[0]) | is_auipc;
    assign op_d[rv_pkg::ALU_SUB]  = r_alt & f3_d[0];
    assign op_d[rv_pkg::ALU_SLT]  = ri_any & f3_d[2];
    assign op_d[rv_pkg::ALU_SLTU] = ri_any & f3_d[3];
    assign op_d[rv_pkg::ALU_XOR]  = ri_any & f3_d[4];
    assign op_d[rv_pkg::ALU_OR]   = ri_any & f3_d[6];
    assign op_d[rv_pkg::ALU_AND]  = ri_any & f3_d[7];
    assign op_d[rv_pkg::ALU_SLL]  = (r_base | i_sh0) & f3_d[1];
    assign op_d[rv_pkg::ALU_SRL]  = (r_base | i_sh0) & f3_d[5];
    assign op_d[rv_pkg::ALU_SRA]  = (r_alt | i_alt) & f3_d[5];
    assign op_d[rv_pkg::ALU_PASS] = is_lui;
    assign op_d[rv_pkg::ALU_LINK] = is_jal | is_jalr;

    assign imm_i = {{20{iss.inst[31]}}, iss.inst[31:20]};
    assign imm_b = {{20{iss.inst[31]}}, iss.inst[7], iss.inst[30:25], iss.inst[11:8], 1'b0};
    assign imm_u = {iss.inst[31:12], 12'b0};
    assign imm_j = {{12{iss.inst[31]}}, iss.inst[19:12], iss.inst[20], iss.inst[30:21], 1'b0};

    assign imm = ({32{is_imm | is_jalr}}   & imm_i)
               | ({32{is_branch}}          & imm_b)
               | ({32{is_lui | is_auipc}}  & imm_u)
               | ({32{is_jal}}             & imm_j);

    assign br_eq    = iss.src1 == iss.src2;
    assign br_lt    = $signed(iss.src1) < $signed(iss.src2);
    assign br_ltu   = iss.src1 < iss.src2;
    assign br_taken = (f3_d[rv_pkg::F3_BEQ]  &  br_eq)
                    | (f3_d[rv_pkg::F3_BNE]  & ~br_eq)
                    | (f3_d[rv_pkg::F3_BLT]  &  br_lt)
                    | (f3_d[rv_pkg::F3_BGE]  & ~br_lt)
                    | (f3_d[rv_pkg::F3_BLTU] &  br_ltu)
                    | (f3_d[rv_pkg::F3_BGEU] & ~br_ltu);

    assign a_d      = (is_auipc | is_jal | is_jalr) ? iss.pc : iss.src1;
    assign b_d      = is_reg ? iss.src2 : imm;
    assign target_d = is_jalr ? ((iss.src1 + imm) & ~32'd1) : iss.pc + imm;
    assign is_shift = op_d[rv_pkg::ALU_SLL] | op_d[rv_pkg::ALU_SRL] | op_d[rv_pkg::ALU_SRA];

    assign iss.ready = (state == S_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (iss.valid) state <= (is_shift && b_d[4:0] != 5'd0) ? S_SHIFT : S_DONE;
                S_SHIFT: if (cnt_q == 5'd1) state <= S_DONE;
                S_DONE:  if (res.ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid && iss.ready) begin
            a_q        <= a_d;
            b_q        <= b_d;
            op_q       <= op_d;
            rd_q       <= iss.inst[11:7];
            cnt_q      <= b_d[4:0];
            target_q   <= target_d;
            wen_q      <= |op_d;
            redirect_q <= is_jal | is_jalr | (is_branch & br_taken);
            illegal_q  <= ~(|op_d | is_branch);
        end else if (state == S_SHIFT) begin
            cnt_q <= cnt_q - 5'd1;
            if (op_q[rv_pkg::ALU_SLL])
                a_q <= {a_q[30:0], 1'b0};
            else if (op_q[rv_pkg::ALU_SRL])
                a_q <= {1'b0, a_q[31:1]};
            else
                a_q <= {a_q[31], a_q[31:1]}; // Arithmetic
        end
    end

    // Shift ops leave their result in a_q
    assign alu_res = ({32{op_q[rv_pkg::ALU_ADD]}}  & (a_q + b_q))
                   | ({32{op_q[rv_pkg::ALU_SUB]}}  & (a_q - b_q))
                   | ({32{op_q[rv_pkg::ALU_SLT]}}  & {31'd0, $signed(a_q) < $signed(b_q)})
                   | ({32{op_q[rv_pkg::ALU_SLTU]}} & {31'd0, a_q < b_q})
                   | ({32{op_q[rv_pkg::ALU_AND]}}  & (a_q & b_q))
                   | ({32{op_q[rv_pkg::ALU_OR]}}   & (a_q | b_q))
                   | ({32{op_q[rv_pkg::ALU_XOR]}}  & (a_q ^ b_q))
                   | ({32{op_q[rv_pkg::ALU_SLL] | op_q[rv_pkg::ALU_SRL]
                         | op_q[rv_pkg::ALU_SRA]}} & a_q)
                   | ({32{op_q[rv_pkg::ALU_PASS]}} & b_q)
                   | ({32{op_q[rv_pkg::ALU_LINK]}} & (a_q + 32'd4));

    assign res.valid    = (state == S_DONE);
    assign res.rd       = rd_q;
    assign res.wdata    = wen_q ? alu_res : '0;
    assign res.wen      = wen_q;
    assign res.target   = target_q;
    assign res.redirect = redirect_q;
    assign res.illegal  = illegal_q;

    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        res.valid && !res.ready |=> res.valid && $stable(res.wdata) && $stable(res.rd)
            && $stable(res.target) && $stable({res.wen, res.redirect, res.illegal}));

    a_busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        iss.valid && iss.ready |=> state != S_IDLE && !iss.ready);

endmodule

// File: rtl/retire_collect.sv
`timescale 1ns/1ps

module retire_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic             clk,
    input  logic             rst,
    result_if.collect        lanes [NUM_LANES],
    output logic             ret_valid,
    input  logic             ret_ready,
    output rv_pkg::reg_idx_t ret_rd,
    output rv_pkg::word_t    ret_wdata,
    output rv_pkg::word_t    ret_target,
    output logic             ret_wen,
    output logic             ret_redirect,
    output logic             ret_illegal
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] ptr;
    logic             v_arr   [NUM_LANES];
    rv_pkg::reg_idx_t rd_arr  [NUM_LANES];
    rv_pkg::word_t    wd_arr  [NUM_LANES];
    rv_pkg::word_t    tgt_arr [NUM_LANES];
    logic [2:0]       flg_arr [NUM_LANES]; // wen, redirect, illegal

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_gather
        assign v_arr[g]       = lanes[g].valid;
        assign rd_arr[g]      = lanes[g].rd;
        assign wd_arr[g]      = lanes[g].wdata;
        assign tgt_arr[g]     = lanes[g].target;
        assign flg_arr[g]     = {lanes[g].wen, lanes[g].redirect, lanes[g].illegal};
        assign lanes[g].ready = ret_ready && (ptr == PTR_W'(g));
    end

    assign ret_valid  = v_arr[ptr];
    assign ret_rd     = rd_arr[ptr];
    assign ret_wdata  = wd_arr[ptr];
    assign ret_target = tgt_arr[ptr];
    assign {ret_wen, ret_redirect, ret_illegal} = flg_arr[ptr];

    // Same order as issue, so retirement stays in program order
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (ret_valid && ret_ready) begin
            ptr <= (ptr == PTR_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

// File: rtl/decode_cluster.sv
`timescale 1ns/1ps

module decode_cluster #(
    parameter int NUM_LANES = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  rv_pkg::word_t    in_pc,
    input  rv_pkg::word_t    in_inst,
    input  rv_pkg::word_t    in_src1,
    input  rv_pkg::word_t    in_src2,
    output logic             ret_valid,
    input  logic             ret_ready,
    output rv_pkg::reg_idx_t ret_rd,
    output rv_pkg::word_t    ret_wdata,
    output logic             ret_wen,
    output logic             ret_redirect,
    output rv_pkg::word_t    ret_target,
    output logic             ret_illegal
);

    issue_if  iss_bus [NUM_LANES] ();
    result_if res_bus [NUM_LANES] ();

    issue_dispatch #(.NUM_LANES(NUM_LANES)) u_issue_dispatch (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .in_src1  (in_src1),
        .in_src2  (in_src2),
        .lanes    (iss_bus)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        decode_exec_lane u_lane (
            .clk (clk),
            .rst (rst),
            .iss (iss_bus[g]),
            .res (res_bus[g])
        );
    end

    retire_collect #(.NUM_LANES(NUM_LANES)) u_retire_collect (
        .clk          (clk),
        .rst          (rst),
        .lanes        (res_bus),
        .ret_valid    (ret_valid),
        .ret_ready    (ret_ready),
        .ret_rd       (ret_rd),
        .ret_wdata    (ret_wdata),
        .ret_target   (ret_target),
        .ret_wen      (ret_wen),
        .ret_redirect (ret_redirect),
        .ret_illegal  (ret_illegal)
    );

endmodule

// File: tests/tb_decode_cluster.sv
`timescale 1ns/1ps

module tb_decode_cluster;

    localparam int num_inst = 2000;
    localparam int op_of_f3 [8] = '{rv_pkg::ALU_ADD, rv_pkg::ALU_SLL, rv_pkg::ALU_SLT,
        rv_pkg::ALU_SLTU, rv_pkg::ALU_XOR, rv_pkg::ALU_SRL, rv_pkg::ALU_OR, rv_pkg::ALU_AND};
    localparam logic [6:0] bad_opc [4] = '{7'h03, 7'h23, 7'h73, 7'h0f}; // Load, store, CSR, fence

    typedef struct packed {
        rv_pkg::reg_idx_t rd;
        rv_pkg::word_t    wdata;
        rv_pkg::word_t    target;
        logic             wen;
        logic             redirect;
        logic             illegal;
        logic             has_target;
    } expect_t;

    logic             clk, rst, in_valid, in_ready, ret_valid, ret_ready;
    logic             ret_wen, ret_redirect, ret_illegal;
    rv_pkg::word_t    in_pc, in_inst, in_src1, in_src2, ret_wdata, ret_target;
    rv_pkg::reg_idx_t ret_rd;
    rv_pkg::word_t    stim_rng = 32'd37;
    rv_pkg::word_t    ready_rng = 32'd37;
    expect_t          exp_q [$];

    decode_cluster #(.NUM_LANES(4)) u_decode_cluster (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic rv_pkg::word_t next_rand(inout rv_pkg::word_t state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic rv_pkg::word_t alu_eval(int op, rv_pkg::word_t a, rv_pkg::word_t b);
        case (op)
            rv_pkg::ALU_ADD:  return a + b;
            rv_pkg::ALU_SUB:  return a - b;
            rv_pkg::ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: return {31'd0, a < b};
            rv_pkg::ALU_AND:  return a & b;
            rv_pkg::ALU_OR:   return a | b;
            rv_pkg::ALU_XOR:  return a ^ b;
            rv_pkg::ALU_SLL:  return a << b[4:0];
            rv_pkg::ALU_SRL:  return a >> b[4:0];
            rv_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            default:          return 32'd0; // Illegal, nothing written
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
        case (f3)
            rv_pkg::F3_BEQ:  return a == b;
            rv_pkg::F3_BNE:  return a != b;
            rv_pkg::F3_BLT:  return $signed(a) < $signed(b);
            rv_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            rv_pkg::F3_BLTU: return a < b;
            default:         return a >= b;
        endcase
    endfunction

    // Expected retire fields for one instruction
    function automatic expect_t model(rv_pkg::word_t pc, rv_pkg::word_t inst,
                                      rv_pkg::word_t s1, rv_pkg::word_t s2);
        expect_t       e;
        logic [6:0]    f7;
        logic [2:0]    f3;
        rv_pkg::word_t imm_i;
        int            op;
        f7    = inst[31:25];
        f3    = inst[14:12];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        e     = '0;
        e.rd  = inst[11:7];
        op    = -1;
        case (inst[6:0])
            rv_pkg::OP_REG: begin
                if (f7 == 7'h00)
                    op = op_of_f3[f3];
                else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
                    op = (f3 == 3'd0) ? rv_pkg::ALU_SUB : rv_pkg::ALU_SRA;
                e.wdata = alu_eval(op, s1, s2);
            end
            rv_pkg::OP_IMM: begin
                if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00)
                    op = op_of_f3[f3];
                else if (f3 == 3'd5 && f7 == 7'h20)
                    op = rv_pkg::ALU_SRA;
                e.wdata = alu_eval(op, s1, imm_i); // Shift amount is imm[4:0]
            end
            rv_pkg::OP_LUI: begin
                op      = rv_pkg::ALU_PASS;
                e.wdata = {inst[31:12], 12'd0};
            end
            rv_pkg::OP_AUIPC: begin
                op      = rv_pkg::ALU_ADD;
                e.wdata = pc + {inst[31:12], 12'd0};
            end
            rv_pkg::OP_JAL, rv_pkg::OP_JALR: begin
                if (inst[6:0] == rv_pkg::OP_JAL || f3 == 3'd0) begin
                    op           = rv_pkg::ALU_LINK;
                    e.wdata      = pc + 32'd4;
                    e.redirect   = 1'b1;
                    e.has_target = 1'b1;
                    if (inst[6:0] == rv_pkg::OP_JAL)
                        e.target = pc + {{12{inst[31]}}, inst[19:12], inst[20],
                                         inst[30:21], 1'b0};
                    else
                        e.target = (s1 + imm_i) & ~32'd1;
                end
            end
            rv_pkg::OP_BRANCH: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    e.has_target = 1'b1;
                    e.redirect   = branch_taken(f3, s1, s2);
                    e.target     = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        e.wen     = (op >= 0);
        e.illegal = !e.wen && !e.has_target;
        return e;
    endfunction

    // Random instruction, mostly from legal classes
    function automatic rv_pkg::word_t make_inst();
        rv_pkg::word_t r;
        logic [2:0]    f3;
        r  = next_rand(stim_rng);
        f3 = r[14:12];
        case (next_rand(stim_rng) >> 28)
            0, 1, 2: begin
                r[6:0]   = rv_pkg::OP_REG;
                r[31:25] = (r[31] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            end
            3, 4, 5: begin
                r[6:0] = rv_pkg::OP_IMM;
                if (f3 == 3'd1 || f3 == 3'd5)
                    r[31:25] = (r[31] && f3 == 3'd5) ? 7'h20 : 7'h00;
            end
            6:       r[6:0] = rv_pkg::OP_LUI;
            7:       r[6:0] = rv_pkg::OP_AUIPC;
            8:       r[6:0] = rv_pkg::OP_JAL;
            9:       r = {r[31:15], 3'd0, r[11:7], rv_pkg::OP_JALR};
            10, 11:  r = {r[31:15], f3[2] | f3[1], f3[1:0], r[11:7], rv_pkg::OP_BRANCH};
            12:      r = {7'h01, r[24:7], rv_pkg::OP_REG}; // M extension
            13:      r[6:0] = bad_opc[r[1:0]];
            14:      r = {r[31:15], 2'b01, r[12], r[11:7], rv_pkg::OP_BRANCH};
            default: r = {r[31:15], 1'b1, r[13:12], r[11:7], rv_pkg::OP_JALR};
        endcase
        return r;
    endfunction

    task automatic stop_failed();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_word(string name, rv_pkg::word_t got, rv_pkg::word_t want);
        if (got !== want) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
            stop_failed();
        end
    endtask

    task automatic check_reg(string name, rv_pkg::reg_idx_t got, rv_pkg::reg_idx_t want);
        if (got !== want) begin
            $display("ERR %s got 0x%02h expected 0x%02h", name, got, want);
            stop_failed();
        end
    endtask

    task automatic check_flag(string name, logic got, logic want);
        if (got !== want) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
            stop_failed();
        end
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        in_src1   = '0;
        in_src2   = '0;
        ret_ready = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag("in_ready", in_ready, 1'b1); // All lanes idle out of reset
        for (int i = 0; i < num_inst; i++) begin
            while ((next_rand(stim_rng) >> 30) == 0) begin // Idle gap
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_pc    = next_rand(stim_rng) & ~32'd3;
            in_inst  = make_inst();
            in_src1  = next_rand(stim_rng);
            in_src2  = ((next_rand(stim_rng) >> 30) == 0) ? in_src1 : next_rand(stim_rng);
            in_valid = 1'b1;
            while (!in_ready) @(negedge clk);
            exp_q.push_back(model(in_pc, in_inst, in_src1, in_src2));
            @(negedge clk);
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk); // Room for a stray extra result
        $display("RESULT: PASS");
        $finish;
    end

    // Retire side, ready toggled at random
    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            if (!rst) begin
                ret_ready = (next_rand(ready_rng) >> 30) != 0;
                if (exp_q.size() == 0) begin
                    check_flag("ret_valid", ret_valid, 1'b0);
                end else if (ret_valid && ret_ready) begin
                    e = exp_q.pop_front();
                    check_reg("ret_rd", ret_rd, e.rd);
                    check_word("ret_wdata", ret_wdata, e.wdata);
                    check_flag("ret_wen", ret_wen, e.wen);
                    check_flag("ret_redirect", ret_redirect, e.redirect);
                    check_flag("ret_illegal", ret_illegal, e.illegal);
                    if (e.has_target)
                        check_word("ret_target", ret_target, e.target);
                end
            end
        end
    end

    initial begin
        repeat (16 + num_inst * 40) @(posedge clk);
        $display("Watchdog expired with %0d results still outstanding", exp_q.size());
        stop_failed();
    end

endmodule

// File: sources.f
rtl/rv_pkg.sv
rtl/lane_ifs.sv
rtl/issue_dispatch.sv
rtl/decode_exec_lane.sv
rtl/retire_collect.sv
rtl/decode_cluster.sv
tests/tb_decode_cluster.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_cluster \
    -f sources.f -o sim_decode_cluster
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_decode_cluster > sim.log 2>&1
status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation finished cleanly"
exit 0
